/* common/motor_pkg.sv */
`default_nettype none

package motor_pkg;

  localparam int frame_bits      = 40;
  localparam int pos_bits        = 8;   // 256 positions per electrical cycle
  localparam int amp_bits        = 8;
  localparam int count_bits      = 32;
  localparam int op_bits         = 8;
  localparam int current_bits    = 8;
  localparam int usteps_bits     = 3;
  localparam int period_bits     = 24;
  localparam int steps_bits      = 31;
  localparam int bitcnt_bits     = $clog2(frame_bits + 1);
  localparam int max_microsteps  = 6;
  localparam int min_step_period = 2;
  localparam int quarter_cycle   = 64;  // Positions per quadrant

  localparam logic [op_bits-1:0] op_write_cfg = 8'h01;
  localparam logic [op_bits-1:0] op_move      = 8'h02;

  localparam logic [op_bits-1:0] reg_current     = 8'd0;
  localparam logic [op_bits-1:0] reg_microsteps  = 8'd1;
  localparam logic [op_bits-1:0] reg_enable      = 8'd2;
  localparam logic [op_bits-1:0] reg_step_period = 8'd3;

  // One SPI word, read as a register write or as a move
  typedef union packed {
    struct packed {
      logic [op_bits-1:0]     opcode;
      logic [op_bits-1:0]     reg_addr;
      logic [period_bits-1:0] value;
    } cfg;
    struct packed {
      logic [op_bits-1:0]    opcode;
      logic                  dir;
      logic [steps_bits-1:0] steps;
    } mv;
  } spi_frame_u;

  // First quadrant of 255 * cos(2*pi*i/256)
  localparam logic [amp_bits-1:0] cos_table [quarter_cycle] = '{
    255, 255, 255, 254, 254, 253, 252, 251,
    250, 249, 247, 246, 244, 242, 240, 238,
    236, 233, 231, 228, 225, 222, 219, 215,
    212, 208, 205, 201, 197, 193, 189, 185,
    180, 176, 171, 167, 162, 157, 152, 147,
    142, 136, 131, 126, 120, 115, 109, 103,
     98,  92,  86,  80,  74,  68,  62,  56,
     50,  44,  37,  31,  25,  19,  13,   6
  };

  // Full-cycle cosine from the quarter table, returns {negative, magnitude}
  function automatic logic [amp_bits:0] cos_lookup(input logic [pos_bits-1:0] pos);
    logic [pos_bits-3:0] idx;
    logic [pos_bits-2:0] mirror;
    logic [amp_bits-1:0] mag;
    idx    = pos[pos_bits-3:0];
    mirror = (pos_bits - 1)'(quarter_cycle) - idx;
    if (!pos[pos_bits-2]) begin
      mag = cos_table[idx];  // Quadrants 0 and 2 run forward
    end else if (idx == '0) begin
      mag = '0;  // Zero crossing lies just past the table
    end else begin
      mag = cos_table[mirror[pos_bits-3:0]];
    end
    return {pos[pos_bits-1] ^ pos[pos_bits-2], mag};  // Negative in quadrants 1 and 2
  endfunction

endpackage

`default_nettype wire

/* spi/spi_target.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_target (
  input  wire                             CLK,
  input  wire                             resetn,
  input  wire                             SCK,
  input  wire                             CS,
  input  wire                             COPI,
  output logic                            CIPO,
  input  wire [motor_pkg::frame_bits-1:0] status,
  output logic                            frame_valid,
  output motor_pkg::spi_frame_u           frame
);
  import motor_pkg::*;

  logic [2:0] sck_r;  // Two sync flops plus one for edge detect
  logic [2:0] cs_r;
  logic [1:0] copi_r;
  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic cs_active;
  logic [bitcnt_bits-1:0] bit_cnt;
  logic [frame_bits-1:0] rx_shift;
  logic [frame_bits-1:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r <= '0;
      cs_r  <= '1;  // Idle deselected
    end else begin
      sck_r <= {sck_r[1:0], SCK};
      cs_r  <= {cs_r[1:0], CS};
    end
  end

  always_ff @(posedge CLK) begin
    copi_r <= {copi_r[0], COPI};  // Same latency as SCK
  end

  assign sck_rise  = sck_r[1] & ~sck_r[2];
  assign sck_fall  = ~sck_r[1] & sck_r[2];
  assign cs_rise   = cs_r[1] & ~cs_r[2];
  assign cs_fall   = ~cs_r[1] & cs_r[2];
  assign cs_active = ~cs_r[1];
  assign CIPO      = tx_shift[frame_bits-1];  // MSB first

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= cs_rise && (bit_cnt == bitcnt_bits'(frame_bits));
      if (cs_fall) begin
        bit_cnt <= '0;
      end else if (cs_active && sck_rise && bit_cnt != '1) begin
        bit_cnt <= bit_cnt + 1'b1;  // Saturates so long frames never alias to 40
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) rx_shift <= {rx_shift[frame_bits-2:0], copi_r[1]};
    if (cs_rise) frame <= rx_shift;
  end

  // Status captured at select, shifted out on falling SCK
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= status;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[frame_bits-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* spi/spi_command.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_command (
  input  wire                                CLK,
  input  wire                                resetn,
  input  wire                                frame_valid,
  input  wire motor_pkg::spi_frame_u         frame,
  input  wire                                halt,
  output logic                               step,
  output logic                               dir,
  output logic                               enable,
  output logic [motor_pkg::current_bits-1:0] current,
  output logic [motor_pkg::usteps_bits-1:0]  microsteps,
  output logic                               move_done
);
  import motor_pkg::*;

  logic [period_bits-1:0] step_period;
  logic [period_bits-1:0] period_cnt;
  logic [steps_bits-1:0] remaining;
  logic cfg_write;
  logic move_load;

  // Opcode sits in the same bits for both views
  assign cfg_write = frame_valid && (frame.cfg.opcode == op_write_cfg);
  assign move_load = frame_valid && (frame.mv.opcode == op_move);

  // Configuration registers
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      current     <= '0;
      microsteps  <= '0;
      enable      <= 1'b0;
      step_period <= period_bits'(min_step_period);
    end else if (cfg_write) begin
      case (frame.cfg.reg_addr)
        reg_current: begin
          current <= frame.cfg.value[current_bits-1:0];
        end
        reg_microsteps: begin
          if (frame.cfg.value > max_microsteps) begin
            microsteps <= usteps_bits'(max_microsteps);
          end else begin
            microsteps <= frame.cfg.value[usteps_bits-1:0];
          end
        end
        reg_enable: begin
          enable <= frame.cfg.value[0];
        end
        reg_step_period: begin
          if (frame.cfg.value < min_step_period) begin
            step_period <= period_bits'(min_step_period);
          end else begin
            step_period <= frame.cfg.value;
          end
        end
        default: begin
          // Unknown address, nothing to write
        end
      endcase
    end
  end

  // Move engine
  // A loaded move waits one full period before its first step
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      remaining  <= '0;
      period_cnt <= '0;
      step       <= 1'b0;
      dir        <= 1'b0;
      move_done  <= 1'b1;
    end else begin
      step <= 1'b0;
      if (halt) begin
        remaining <= '0;  // Drop whatever is left
        move_done <= 1'b1;
      end else if (move_load) begin
        remaining  <= frame.mv.steps;  // Also replaces a move in flight
        dir        <= frame.mv.dir;
        period_cnt <= period_bits'(1);
        move_done  <= (frame.mv.steps == '0);
      end else if (remaining != '0) begin
        if (period_cnt >= step_period) begin
          step       <= 1'b1;
          remaining  <= remaining - 1'b1;
          period_cnt <= period_bits'(1);
        end else begin
          period_cnt <= period_cnt + 1'b1;
        end
      end else begin
        move_done <= 1'b1;  // Clock after the last step
      end
    end
  end

endmodule

`default_nettype wire

/* microstepper/microstep_phase.sv */
`timescale 1ns/1ps
`default_nettype none

module microstep_phase (
  input  wire                               CLK,
  input  wire                               resetn,
  input  wire                               step,
  input  wire                               dir,
  input  wire                               enable,
  input  wire [motor_pkg::current_bits-1:0] current,
  input  wire [motor_pkg::usteps_bits-1:0]  microsteps,
  output logic [motor_pkg::pos_bits-1:0]    position,
  output logic [motor_pkg::amp_bits-1:0]    amp_a,
  output logic [motor_pkg::amp_bits-1:0]    amp_b,
  output logic                              sign_a,
  output logic                              sign_b
);
  import motor_pkg::*;

  logic [pos_bits-1:0] increment;
  logic [amp_bits:0] lut_a;  // {negative, magnitude}
  logic [amp_bits:0] lut_b;
  logic [amp_bits+current_bits-1:0] prod_a;
  logic [amp_bits+current_bits-1:0] prod_b;

  // 2^microsteps positions per step
  assign increment = pos_bits'(1) << microsteps;

  // Electrical position, wraps modulo 256
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      position <= '0;
    end else if (enable && step) begin
      if (dir) begin
        position <= position + increment;
      end else begin
        position <= position - increment;
      end
    end
  end

  // Coil B lags coil A by a quarter cycle
  assign lut_a = cos_lookup(position);
  assign lut_b = cos_lookup(position - pos_bits'(quarter_cycle));

  // Current scaling
  assign prod_a = lut_a[amp_bits-1:0] * current;
  assign prod_b = lut_b[amp_bits-1:0] * current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      amp_a  <= '0;
      amp_b  <= '0;
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else begin
      amp_a  <= enable ? prod_a[amp_bits+current_bits-1 -: amp_bits] : '0;  // Keep upper byte
      amp_b  <= enable ? prod_b[amp_bits+current_bits-1 -: amp_bits] : '0;
      sign_a <= lut_a[amp_bits];
      sign_b <= lut_b[amp_bits];
    end
  end

endmodule

`default_nettype wire

/* microstepper/hbridge_pwm.sv */
`timescale 1ns/1ps
`default_nettype none

module hbridge_pwm (
  input  wire                           CLK,
  input  wire                           resetn,
  input  wire [motor_pkg::amp_bits-1:0] amp_a,
  input  wire [motor_pkg::amp_bits-1:0] amp_b,
  input  wire                           sign_a,
  input  wire                           sign_b,
  output logic                          phase_a1,
  output logic                          phase_a2,
  output logic                          phase_b1,
  output logic                          phase_b2
);
  import motor_pkg::*;

  logic [amp_bits-1:0] pwm_cnt;

  // Leg pair for one bridge, {leg 1, leg 2}
  // Sign picks the leg, so both are never on together
  function automatic logic [1:0] bridge_legs(
    input logic                neg,
    input logic [amp_bits-1:0] amp,
    input logic [amp_bits-1:0] cnt
  );
    logic on;
    on = (cnt < amp);  // Zero magnitude never turns on
    return {on & ~neg, on & neg};
  endfunction

  // Free-running 256-clock PWM period
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      {phase_a1, phase_a2} <= bridge_legs(sign_a, amp_a, pwm_cnt);
      {phase_b1, phase_b2} <= bridge_legs(sign_b, amp_b, pwm_cnt);
    end
  end

endmodule

`default_nettype wire

/* hdl/quad_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module quad_encoder (
  input  wire                                    CLK,
  input  wire                                    resetn,
  input  wire                                    enc_a,
  input  wire                                    enc_b,
  output logic signed [motor_pkg::count_bits-1:0] count,
  output logic                                   fault
);
  import motor_pkg::*;

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] curr;  // {a, b}
  logic [1:0] prev;
  logic [1:0] delta;
  logic forward;

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
  end

  assign curr  = {a_sync[1], b_sync[1]};
  assign delta = curr ^ prev;

  // A leads B: 00 -> 10 -> 11 -> 01
  assign forward = curr[1] ^ prev[0];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
      prev  <= curr;  // Track inputs so release shows no transition
    end else begin
      prev <= curr;
      case (delta)
        2'b00: begin
          // No movement
        end
        2'b11: begin
          fault <= 1'b1;  // Skipped a state, sticky
        end
        default: begin
          if (forward) begin
            count <= count + count_bits'(1);
          end else begin
            count <= count - count_bits'(1);
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/motor_core.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_core (
  input  wire  CLK,
  input  wire  resetn,
  input  wire  SCK,
  input  wire  CS,
  input  wire  COPI,
  output logic CIPO,
  input  wire  enc_a,
  input  wire  enc_b,
  input  wire  halt,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic move_done,
  output logic encoder_fault
);
  import motor_pkg::*;

  logic frame_valid;
  spi_frame_u frame;
  logic step;
  logic dir;
  logic enable;
  logic [current_bits-1:0] current;
  logic [usteps_bits-1:0] microsteps;
  logic [pos_bits-1:0] position;
  logic [amp_bits-1:0] amp_a;
  logic [amp_bits-1:0] amp_b;
  logic sign_a;
  logic sign_b;
  logic signed [count_bits-1:0] count;

  // Status word is position then encoder count
  spi_target spi_target_i (
    .CLK         (CLK),
    .resetn      (resetn),
    .SCK         (SCK),
    .CS          (CS),
    .COPI        (COPI),
    .CIPO        (CIPO),
    .status      ({position, count}),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  spi_command spi_command_i (
    .CLK         (CLK),
    .resetn      (resetn),
    .frame_valid (frame_valid),
    .frame       (frame),
    .halt        (halt),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .current     (current),
    .microsteps  (microsteps),
    .move_done   (move_done)
  );

  microstep_phase microstep_phase_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .current    (current),
    .microsteps (microsteps),
    .position   (position),
    .amp_a      (amp_a),
    .amp_b      (amp_b),
    .sign_a     (sign_a),
    .sign_b     (sign_b)
  );

  hbridge_pwm hbridge_pwm_i (
    .CLK      (CLK),
    .resetn   (resetn),
    .amp_a    (amp_a),
    .amp_b    (amp_b),
    .sign_a   (sign_a),
    .sign_b   (sign_b),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2)
  );

  quad_encoder quad_encoder_i (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .count  (count),
    .fault  (encoder_fault)
  );

endmodule

`default_nettype wire

/* dv/motor_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_core_assert (
  input wire CLK,
  input wire resetn,
  input wire step,
  input wire enable,
  input wire phase_a1,
  input wire phase_a2,
  input wire phase_b1,
  input wire phase_b2
);

  int fail_count = 0;  // Failed assertion attempts

  // Both legs of one bridge on would short the supply
  no_shoot_through: assert property (@(posedge CLK) disable iff (!resetn)
    !(phase_a1 && phase_a2) && !(phase_b1 && phase_b2))
    else begin
      $error("bridge has both legs high together");
      fail_count++;
    end

  step_single_clock: assert property (@(posedge CLK) disable iff (!resetn)
    step |=> !step)
    else begin
      $error("step pulse longer than one clock");
      fail_count++;
    end

  // Amplitude and leg registers need two clocks to drain
  legs_off_disabled: assert property (@(posedge CLK) disable iff (!resetn)
    (!enable && !$past(enable) && !$past(enable, 2)) |->
      !(phase_a1 || phase_a2 || phase_b1 || phase_b2))
    else begin
      $error("bridge leg high while disabled");
      fail_count++;
    end

endmodule

`default_nettype wire

/* dv/motor_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_core_tb;
  import motor_pkg::*;

  localparam int frame_clocks = 340;  // Lead, 40 bits of 8 clocks, tail
  localparam int max_frames   = 90;
  localparam int move_budget  = 3000;
  localparam int pwm_budget   = 8 * 270;
  localparam int enc_budget   = 40 * 10;
  localparam int limit_cycles = max_frames * frame_clocks + move_budget + pwm_budget
                                + enc_budget + 2000;

  logic CLK = 1'b0;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic halt;
  logic enc_a;
  logic enc_b;
  wire CIPO;
  wire phase_a1;
  wire phase_a2;
  wire phase_b1;
  wire phase_b2;
  wire move_done;
  wire encoder_fault;

  // Reference model state
  logic [7:0] m_current;
  logic [7:0] m_pos;
  logic [2:0] m_usteps;
  logic m_enable;
  int m_period;
  int m_count;
  int enc_state = 0;  // Index into the Gray sequence
  int errors = 0;
  int checks = 0;

  // Monitor state
  int cycle = 0;
  int last_change = -1;
  int change_cnt = 0;
  int fall_cycle = -1;
  int rise_cycle = -1;
  logic pace_on = 1'b0;
  logic done_seen = 1'b1;
  logic [7:0] seen_pos = 8'd0;

  always #5 CLK = ~CLK;

  motor_core motor_core_i (
    .CLK           (CLK),
    .resetn        (resetn),
    .SCK           (SCK),
    .CS            (CS),
    .COPI          (COPI),
    .CIPO          (CIPO),
    .enc_a         (enc_a),
    .enc_b         (enc_b),
    .halt          (halt),
    .phase_a1      (phase_a1),
    .phase_a2      (phase_a2),
    .phase_b1      (phase_b1),
    .phase_b2      (phase_b2),
    .move_done     (move_done),
    .encoder_fault (encoder_fault)
  );

  bind motor_core motor_core_assert motor_core_assert_i (
    .CLK      (CLK),
    .resetn   (resetn),
    .step     (step),
    .enable   (enable),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2)
  );

  // Tracks position steps and move_done edges
  always @(negedge CLK) begin
    cycle = cycle + 1;
    if (motor_core_i.position != seen_pos) begin
      if (pace_on && last_change >= 0 && cycle - last_change != m_period) begin
        errors++;
        $display("mismatch at %0t: step interval expected %0d got %0d",
                 $time, m_period, cycle - last_change);
      end
      last_change = cycle;
      change_cnt++;
    end
    seen_pos = motor_core_i.position;
    if (done_seen && !move_done) fall_cycle = cycle;
    if (!done_seen && move_done) rise_cycle = cycle;
    done_seen = move_done;
  end

  task automatic compare_int(input string what, input int exp, input int got);
    checks++;
    if (exp != got) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  // Mode 0 host, 4 clocks per SCK phase
  task automatic spi_xfer(input logic [39:0] tx, input int nbits, output logic [39:0] rx);
    int i;
    rx = '0;
    CS = 1'b0;
    repeat (4) @(negedge CLK);
    for (i = 0; i < nbits; i++) begin
      COPI = tx[39 - (i % 40)];
      repeat (4) @(negedge CLK);
      rx = {rx[38:0], CIPO};  // Host samples on rising SCK
      SCK = 1'b1;
      repeat (4) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (4) @(negedge CLK);
    CS = 1'b1;
    repeat (6) @(negedge CLK);  // Frame decoded and applied
  endtask

  task automatic write_reg(input logic [7:0] addr, input int value);
    logic [39:0] rx;
    spi_xfer({op_write_cfg, addr, 24'(value)}, 40, rx);
    case (addr)
      reg_current: m_current = value[7:0];
      reg_microsteps: m_usteps = (value > 6) ? 3'd6 : value[2:0];
      reg_enable: m_enable = value[0];
      reg_step_period: m_period = (value < 2) ? 2 : value;
      default: ;
    endcase
  endtask

  task automatic wait_move_done(input int limit);
    int n;
    n = 0;
    while (move_done !== 1'b1 && n < limit) begin
      @(negedge CLK);
      n++;
    end
    checks++;
    if (move_done !== 1'b1) begin
      errors++;
      $display("move_done did not rise within %0d clocks", limit);
    end
  endtask

  task automatic do_move(input logic dir, input int steps);
    logic [39:0] rx;
    logic [7:0] delta;
    spi_xfer({op_move, dir, 31'(steps)}, 40, rx);
    delta = 8'(steps << m_usteps);
    if (m_enable) m_pos = dir ? m_pos + delta : m_pos - delta;
    wait_move_done(steps * m_period + 20);
  endtask

  task automatic check_status(input string what);
    logic [39:0] rx;
    spi_xfer(40'h0, 40, rx);  // Opcode 0 is a no-op read
    compare_int({what, " position"}, int'(m_pos), int'(rx[39:32]));
    compare_int({what, " count"}, m_count, $signed(rx[31:0]));
  endtask

  // Coil drive as {negative, magnitude}, quarter table mirrored per quadrant
  function automatic logic [8:0] model_coil(input logic [7:0] pos);
    logic [7:0] raw;
    logic [15:0] prod;
    case (pos[7:6])
      2'd0, 2'd2: raw = cos_table[pos[5:0]];
      default: raw = (pos[5:0] == 6'd0) ? 8'd0 : cos_table[6'(64 - int'(pos[5:0]))];
    endcase
    prod = raw * m_current;
    return {pos[7] != pos[6], m_enable ? prod[15:8] : 8'd0};
  endfunction

  task automatic check_pwm(input string what);
    int hi [4];
    logic [8:0] ca;
    logic [8:0] cb;
    hi = '{0, 0, 0, 0};
    repeat (4) @(negedge CLK);
    repeat (256) begin
      @(negedge CLK);
      hi[0] = hi[0] + int'(phase_a1);
      hi[1] = hi[1] + int'(phase_a2);
      hi[2] = hi[2] + int'(phase_b1);
      hi[3] = hi[3] + int'(phase_b2);
    end
    ca = model_coil(m_pos);
    cb = model_coil(m_pos - 8'd64);  // Coil B lags a quarter cycle
    compare_int({what, " a1"}, ca[8] ? 0 : int'(ca[7:0]), hi[0]);
    compare_int({what, " a2"}, ca[8] ? int'(ca[7:0]) : 0, hi[1]);
    compare_int({what, " b1"}, cb[8] ? 0 : int'(cb[7:0]), hi[2]);
    compare_int({what, " b2"}, cb[8] ? int'(cb[7:0]) : 0, hi[3]);
  endtask

  task automatic set_encoder(input int state);
    enc_a = (state == 1) || (state == 2);  // 00, 10, 11, 01
    enc_b = (state >= 2);
  endtask

  initial begin
    int i;
    logic d;
    logic [39:0] rx;
    void'($urandom(32'hf1d1));
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    halt = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    m_current = 8'd0;
    m_usteps = 3'd0;
    m_enable = 1'b0;
    m_period = 2;
    m_pos = 8'd0;
    m_count = 0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;
    repeat (2) @(negedge CLK);
    compare_int("move_done after reset", 1, move_done);

    // Random configuration and moves
    write_reg(reg_enable, 1);
    write_reg(reg_current, 200);
    for (i = 0; i < 10; i++) begin
      write_reg(reg_microsteps, $urandom_range(9, 0));
      write_reg(reg_step_period, $urandom_range(12, 0));
      do_move($urandom_range(1, 0), $urandom_range(16, 1));
      check_status("random move");
    end

    // Step pacing
    write_reg(reg_microsteps, $urandom_range(6, 0));
    write_reg(reg_step_period, $urandom_range(25, 10));
    change_cnt = 0;
    last_change = -1;
    fall_cycle = -1;
    pace_on = 1'b1;
    do_move(1'b1, 3);
    @(negedge CLK);
    pace_on = 1'b0;
    compare_int("move_done low time", 3 * m_period + 1, rise_cycle - fall_cycle);
    compare_int("position changes", 3, change_cnt);
    check_status("paced move");

    // PWM duty at random positions
    write_reg(reg_step_period, 4);
    for (i = 0; i < 4; i++) begin
      write_reg(reg_current, $urandom_range(255, 1));
      do_move($urandom_range(1, 0), $urandom_range(8, 1));
      check_pwm("pwm");
    end
    check_status("after pwm");

    // Encoder walk, then a skipped state
    for (i = 0; i < 30; i++) begin
      d = $urandom_range(1, 0);
      enc_state = d ? (enc_state + 1) % 4 : (enc_state + 3) % 4;
      set_encoder(enc_state);
      m_count = d ? m_count + 1 : m_count - 1;
      repeat ($urandom_range(8, 4)) @(negedge CLK);
    end
    check_status("encoder walk");
    compare_int("encoder_fault before jump", 0, encoder_fault);
    enc_state = (enc_state + 2) % 4;
    set_encoder(enc_state);
    repeat (6) @(negedge CLK);
    compare_int("encoder_fault after jump", 1, encoder_fault);
    check_status("after jump");

    // Halt a long move
    write_reg(reg_step_period, 20);
    spi_xfer({op_move, 1'b1, 31'd200}, 40, rx);
    repeat (300) @(negedge CLK);
    compare_int("move_done during long move", 0, move_done);
    halt = 1'b1;
    @(negedge CLK);
    compare_int("move_done on halt", 1, move_done);
    halt = 1'b0;
    repeat (4) @(negedge CLK);
    // Move starts 4 clocks after CS rises, halt is sampled 307 clocks after
    m_pos = m_pos + 8'(((6 + 300 - 4) / m_period) << m_usteps);
    check_status("halted");
    repeat (200) @(negedge CLK);
    check_status("after halt");

    // Disable, dropped frames, unknown opcode
    write_reg(reg_current, $urandom_range(255, 128));
    write_reg(reg_enable, 0);
    check_pwm("disabled");
    do_move(1'b0, 5);
    check_status("disabled move");
    spi_xfer({op_write_cfg, reg_current, 24'd0}, 39, rx);
    spi_xfer({op_write_cfg, reg_microsteps, 24'((int'(m_usteps) + 1) % 7)}, 41, rx);
    spi_xfer({8'h7f, reg_current, 24'd0}, 40, rx);
    write_reg(reg_enable, 1);
    check_pwm("after dropped frames");
    do_move(1'b1, 3);
    check_status("after dropped frames");

    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             motor_core_i.motor_core_assert_i.fail_count);
    if (errors == 0 && motor_core_i.motor_core_assert_i.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(limit_cycles * 10);
    $display("timeout after %0d clocks, run did not finish", limit_cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/motor_pkg.sv
spi/spi_target.sv
spi/spi_command.sv
microstepper/microstep_phase.sv
microstepper/hbridge_pwm.sv
hdl/quad_encoder.sv
hdl/motor_core.sv
dv/motor_core_assert.sv
dv/motor_core_tb.sv

/* Bender.yml */
package:
  name: motor_core

sources:
  - common/motor_pkg.sv
  - spi/spi_target.sv
  - spi/spi_command.sv
  - microstepper/microstep_phase.sv
  - microstepper/hbridge_pwm.sv
  - hdl/quad_encoder.sv
  - hdl/motor_core.sv
  - target: test
    files:
      - dv/motor_core_assert.sv
      - dv/motor_core_tb.sv
